//--- rtl/vdec_pkg.sv
// vector decoder package with RVV encodings, instruction formats and control enums
package vdec_pkg;

  // latency from instr_valid to ctrl_valid in cycles
  localparam int PIPE_DEPTH = 3;

  // major opcodes
  localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
  localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
  localparam logic [6:0] OPC_VECTOR   = 7'b1010111;

  // funct3 categories of OP-V
  localparam logic [2:0] F3_OPIVV = 3'b000;
  localparam logic [2:0] F3_OPMVV = 3'b010;
  localparam logic [2:0] F3_OPIVI = 3'b011;
  localparam logic [2:0] F3_OPIVX = 3'b100;
  localparam logic [2:0] F3_OPMVX = 3'b110;
  localparam logic [2:0] F3_OPCFG = 3'b111;

  // funct6 of the integer OPI ops
  localparam logic [5:0] F6_VADD   = 6'b000000;
  localparam logic [5:0] F6_VSUB   = 6'b000010;
  localparam logic [5:0] F6_VRSUB  = 6'b000011;
  localparam logic [5:0] F6_VMINU  = 6'b000100;
  localparam logic [5:0] F6_VMIN   = 6'b000101;
  localparam logic [5:0] F6_VMAXU  = 6'b000110;
  localparam logic [5:0] F6_VMAX   = 6'b000111;
  localparam logic [5:0] F6_VAND   = 6'b001001;
  localparam logic [5:0] F6_VOR    = 6'b001010;
  localparam logic [5:0] F6_VXOR   = 6'b001011;
  localparam logic [5:0] F6_VMSEQ  = 6'b011000;
  localparam logic [5:0] F6_VMSNE  = 6'b011001;
  localparam logic [5:0] F6_VMSLTU = 6'b011010;
  localparam logic [5:0] F6_VMSLT  = 6'b011011;
  localparam logic [5:0] F6_VMSLEU = 6'b011100;
  localparam logic [5:0] F6_VMSLE  = 6'b011101;
  localparam logic [5:0] F6_VMSGTU = 6'b011110;
  localparam logic [5:0] F6_VMSGT  = 6'b011111;
  localparam logic [5:0] F6_VSLL   = 6'b100101;
  localparam logic [5:0] F6_VSRL   = 6'b101000;
  localparam logic [5:0] F6_VSRA   = 6'b101001;

  // funct6 of the single-width reductions (OPMVV)
  localparam logic [5:0] F6_VREDSUM  = 6'b000000;
  localparam logic [5:0] F6_VREDAND  = 6'b000001;
  localparam logic [5:0] F6_VREDOR   = 6'b000010;
  localparam logic [5:0] F6_VREDXOR  = 6'b000011;
  localparam logic [5:0] F6_VREDMINU = 6'b000100;
  localparam logic [5:0] F6_VREDMIN  = 6'b000101;
  localparam logic [5:0] F6_VREDMAXU = 6'b000110;
  localparam logic [5:0] F6_VREDMAX  = 6'b000111;

  // memory element widths and addressing mode
  localparam logic [2:0] W_8         = 3'b000;
  localparam logic [2:0] W_16        = 3'b101;
  localparam logic [2:0] W_32        = 3'b110;
  localparam logic [1:0] MOP_STRIDED = 2'b10;

  // legal OPI forms, bit order {vv, vx, vi}
  localparam logic [2:0] FORM_ALL   = 3'b111;
  localparam logic [2:0] FORM_VV_VX = 3'b110;
  localparam logic [2:0] FORM_VX_VI = 3'b011;

  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] vs1;
    logic [2:0] funct3;
    logic [4:0] vd;
    logic [6:0] opcode;
  } varith_fmt_t;

  typedef struct packed {
    logic [2:0] nf;
    logic       mew;
    logic [1:0] mop;
    logic       vm;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] width;
    logic [4:0] vd;
    logic [6:0] opcode;
  } vmem_fmt_t;

  // same word, arithmetic or load/store view
  typedef union packed {
    varith_fmt_t arith;
    vmem_fmt_t   mem;
  } vinstr_u;

  typedef enum logic [2:0] {
    CL_OPI_VV, CL_OPI_VX, CL_OPI_VI, CL_OPM_VV, CL_CFG, CL_LOAD, CL_STORE, CL_BAD
  } vclass_t;

  typedef enum logic [5:0] {
    OP_VADD, OP_VSUB, OP_VRSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT, OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT,
    OP_VSLL, OP_VSRL, OP_VSRA,
    OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
    OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX,
    OP_VSETVLI, OP_VSETIVLI, OP_VSETVL, OP_LOAD, OP_STORE, OP_BAD
  } vop_t;

  typedef enum logic [1:0] {SRC_V, SRC_X, SRC_I} src_kind_t;

  typedef enum logic [2:0] {FU_NONE, FU_ALU, FU_RED, FU_LOAD, FU_STORE, FU_CFG} fu_t;

  typedef enum logic [3:0] {
    VALU_NONE, VALU_ADD, VALU_SUB, VALU_AND, VALU_OR, VALU_XOR,
    VALU_SLL, VALU_SRL, VALU_SRA, VALU_COMP, VALU_MM
  } aluop_t;

  typedef enum logic [2:0] {VSEQ, VSNE, VSLTU, VSLT, VSLEU, VSLE, VSGTU, VSGT} comp_t;

  typedef enum logic [1:0] {MIN, MINU, MAX, MAXU} minmax_t;

endpackage

//--- rtl/vdec_field_if.sv
// stage 1 to stage 2 bus with the registered instruction word and its class
`timescale 1ns/1ps

interface vdec_field_if import vdec_pkg::*; ();

  // one-cycle strobe per instruction
  logic    valid;
  vinstr_u word;
  vclass_t vclass;

  modport src (
    output valid,
    output word,
    output vclass
  );

  modport dst (
    input valid,
    input word,
    input vclass
  );

endinterface

//--- rtl/vdec_op_if.sv
// stage 2 to stage 3 bus with the decoded operation and operand fields
`timescale 1ns/1ps

interface vdec_op_if import vdec_pkg::*; ();

  logic       valid;
  vop_t       op;
  src_kind_t  rs1_kind;
  // strided load or store, rs2 holds the stride
  logic       strided;
  logic [2:0] mem_width;
  logic [4:0] vs1;
  logic [4:0] vs2;
  logic [4:0] vd;

  modport src (
    output valid, op, rs1_kind, strided, mem_width,
    output vs1, vs2, vd
  );

  modport dst (
    input valid, op, rs1_kind, strided, mem_width,
    input vs1, vs2, vd
  );

endinterface

//--- rtl/vdec_field_stage.sv
// decoder stage 1, registers the instruction and classifies it by opcode and funct3
`timescale 1ns/1ps

module vdec_field_stage import vdec_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  vdec_field_if.src   fo
);

  vinstr_u word_in;
  vclass_t cls;
  logic    width_ok;

  assign word_in = instr;

  // only 8/16/32-bit elements are supported
  assign width_ok = word_in.mem.width inside {W_8, W_16, W_32};

  always_comb begin
    cls = CL_BAD;
    case (word_in.arith.opcode)
      OPC_LOAD_FP: begin
        if (width_ok) cls = CL_LOAD;
      end
      OPC_STORE_FP: begin
        if (width_ok) cls = CL_STORE;
      end
      OPC_VECTOR: begin
        case (word_in.arith.funct3)
          F3_OPIVV: cls = CL_OPI_VV;
          F3_OPIVX: cls = CL_OPI_VX;
          F3_OPIVI: cls = CL_OPI_VI;
          F3_OPMVV: cls = CL_OPM_VV;
          F3_OPCFG: cls = CL_CFG;
          // nothing kept in OPMVX
          F3_OPMVX: cls = CL_BAD;
          default:  cls = CL_BAD;
        endcase
      end
      default: cls = CL_BAD;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fo.valid <= 1'b0;
    end else begin
      fo.valid <= instr_valid;
    end
  end

  // word and class hold between strobes
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      fo.word   <= word_in;
      fo.vclass <= cls;
    end
  end

endmodule

//--- rtl/vdec_op_stage.sv
// decoder stage 2, resolves class and funct6 into one operation and the rs1 source
`timescale 1ns/1ps

module vdec_op_stage import vdec_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  vdec_field_if.dst fi,
  vdec_op_if.src    oo
);

  logic [5:0] f6;
  // bits 31:30 select the config form
  logic [1:0] cfg_bits;
  vop_t       opi_op;
  vop_t       red_op;
  vop_t       op_d;
  logic [2:0] opi_forms;
  logic [2:0] form_sel;
  src_kind_t  rs1_d;
  logic       is_mem;

  assign f6       = fi.word.arith.funct6;
  assign cfg_bits = fi.word.arith.funct6[5:4];
  assign is_mem   = (fi.vclass == CL_LOAD) || (fi.vclass == CL_STORE);

  always_comb begin
    case (f6)
      F6_VADD:   opi_op = OP_VADD;
      F6_VSUB:   opi_op = OP_VSUB;
      F6_VRSUB:  opi_op = OP_VRSUB;
      F6_VMINU:  opi_op = OP_VMINU;
      F6_VMIN:   opi_op = OP_VMIN;
      F6_VMAXU:  opi_op = OP_VMAXU;
      F6_VMAX:   opi_op = OP_VMAX;
      F6_VAND:   opi_op = OP_VAND;
      F6_VOR:    opi_op = OP_VOR;
      F6_VXOR:   opi_op = OP_VXOR;
      F6_VMSEQ:  opi_op = OP_VMSEQ;
      F6_VMSNE:  opi_op = OP_VMSNE;
      F6_VMSLTU: opi_op = OP_VMSLTU;
      F6_VMSLT:  opi_op = OP_VMSLT;
      F6_VMSLEU: opi_op = OP_VMSLEU;
      F6_VMSLE:  opi_op = OP_VMSLE;
      F6_VMSGTU: opi_op = OP_VMSGTU;
      F6_VMSGT:  opi_op = OP_VMSGT;
      F6_VSLL:   opi_op = OP_VSLL;
      F6_VSRL:   opi_op = OP_VSRL;
      F6_VSRA:   opi_op = OP_VSRA;
      default:   opi_op = OP_BAD;
    endcase
  end

  // forms each OPI op may take
  always_comb begin
    if (f6 inside {F6_VSUB, F6_VMINU, F6_VMIN, F6_VMAXU, F6_VMAX, F6_VMSLTU, F6_VMSLT}) begin
      opi_forms = FORM_VV_VX;
    end else if (f6 inside {F6_VRSUB, F6_VMSGTU, F6_VMSGT}) begin
      opi_forms = FORM_VX_VI;
    end else begin
      opi_forms = FORM_ALL;
    end
  end

  always_comb begin
    case (f6)
      F6_VREDSUM:  red_op = OP_VREDSUM;
      F6_VREDAND:  red_op = OP_VREDAND;
      F6_VREDOR:   red_op = OP_VREDOR;
      F6_VREDXOR:  red_op = OP_VREDXOR;
      F6_VREDMINU: red_op = OP_VREDMINU;
      F6_VREDMIN:  red_op = OP_VREDMIN;
      F6_VREDMAXU: red_op = OP_VREDMAXU;
      F6_VREDMAX:  red_op = OP_VREDMAX;
      default:     red_op = OP_BAD;
    endcase
  end

  always_comb begin
    form_sel = 3'b000;
    op_d     = OP_BAD;
    rs1_d    = SRC_V;
    case (fi.vclass)
      CL_OPI_VV: form_sel = 3'b100;
      CL_OPI_VX: begin
        form_sel = 3'b010;
        rs1_d    = SRC_X;
      end
      CL_OPI_VI: begin
        form_sel = 3'b001;
        rs1_d    = SRC_I;
      end
      CL_OPM_VV: op_d = red_op;
      CL_CFG: begin
        if (!cfg_bits[1]) begin
          op_d  = OP_VSETVLI;
          rs1_d = SRC_X;
        end else if (cfg_bits[0]) begin
          // uimm in the rs1 field
          op_d  = OP_VSETIVLI;
          rs1_d = SRC_I;
        end else begin
          op_d  = OP_VSETVL;
          rs1_d = SRC_X;
        end
      end
      CL_LOAD: begin
        op_d  = OP_LOAD;
        rs1_d = SRC_X;
      end
      CL_STORE: begin
        op_d  = OP_STORE;
        rs1_d = SRC_X;
      end
      default: op_d = OP_BAD;
    endcase
    if (|(opi_forms & form_sel)) op_d = opi_op;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      oo.valid <= 1'b0;
    end else begin
      oo.valid <= fi.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fi.valid) begin
      oo.op        <= op_d;
      oo.rs1_kind  <= rs1_d;
      oo.strided   <= is_mem && (fi.word.mem.mop == MOP_STRIDED);
      // zero for anything that is not a memory access
      oo.mem_width <= is_mem ? fi.word.mem.width : 3'b000;
      oo.vs1       <= fi.word.arith.vs1;
      oo.vs2       <= fi.word.arith.vs2;
      oo.vd        <= fi.word.arith.vd;
    end
  end

endmodule

//--- rtl/vdec_ctrl_stage.sv
// decoder stage 3, maps the operation onto the registered control outputs
`timescale 1ns/1ps

module vdec_ctrl_stage import vdec_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  vdec_op_if.dst     oi,
  output logic       ctrl_valid,
  output logic       illegal,
  output fu_t        fu,
  output aluop_t     aluop,
  output comp_t      comp,
  output minmax_t    minmax,
  output logic       is_signed,
  output src_kind_t  rs1_kind,
  output logic       rs2_is_x,
  output logic       sign_extend,
  output logic       single_bit_op,
  output logic       vreg_wen,
  output logic       xreg_wen,
  output logic [2:0] mem_width,
  output logic [4:0] vs1,
  output logic [4:0] vs2,
  output logic [4:0] vd
);

  fu_t     fu_d;
  aluop_t  aluop_d;
  comp_t   comp_d;
  minmax_t minmax_d;

  always_comb begin
    case (oi.op)
      OP_VADD, OP_VSUB, OP_VRSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX, OP_VAND, OP_VOR,
      OP_VXOR, OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT, OP_VMSLEU, OP_VMSLE, OP_VMSGTU,
      OP_VMSGT, OP_VSLL, OP_VSRL, OP_VSRA: fu_d = FU_ALU;
      OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
      OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: fu_d = FU_RED;
      OP_VSETVLI, OP_VSETIVLI, OP_VSETVL: fu_d = FU_CFG;
      OP_LOAD:  fu_d = FU_LOAD;
      OP_STORE: fu_d = FU_STORE;
      default:  fu_d = FU_NONE;
    endcase
  end

  always_comb begin
    case (oi.op)
      OP_VADD, OP_VREDSUM:  aluop_d = VALU_ADD;
      OP_VSUB, OP_VRSUB:    aluop_d = VALU_SUB;
      OP_VAND, OP_VREDAND:  aluop_d = VALU_AND;
      OP_VOR, OP_VREDOR:    aluop_d = VALU_OR;
      OP_VXOR, OP_VREDXOR:  aluop_d = VALU_XOR;
      OP_VSLL:              aluop_d = VALU_SLL;
      OP_VSRL:              aluop_d = VALU_SRL;
      OP_VSRA:              aluop_d = VALU_SRA;
      OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
      OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT: aluop_d = VALU_COMP;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
      OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: aluop_d = VALU_MM;
      default:              aluop_d = VALU_NONE;
    endcase
  end

  // sub-codes default to VSEQ and MIN when unused
  always_comb begin
    case (oi.op)
      OP_VMSNE:  comp_d = VSNE;
      OP_VMSLTU: comp_d = VSLTU;
      OP_VMSLT:  comp_d = VSLT;
      OP_VMSLEU: comp_d = VSLEU;
      OP_VMSLE:  comp_d = VSLE;
      OP_VMSGTU: comp_d = VSGTU;
      OP_VMSGT:  comp_d = VSGT;
      default:   comp_d = VSEQ;
    endcase
    case (oi.op)
      OP_VMINU, OP_VREDMINU: minmax_d = MINU;
      OP_VMAX, OP_VREDMAX:   minmax_d = MAX;
      OP_VMAXU, OP_VREDMAXU: minmax_d = MAXU;
      default:               minmax_d = MIN;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_valid <= 1'b0;
      illegal    <= 1'b0;
      vreg_wen   <= 1'b0;
      xreg_wen   <= 1'b0;
    end else begin
      ctrl_valid <= oi.valid;
      if (oi.valid) begin
        illegal  <= (oi.op == OP_BAD);
        vreg_wen <= fu_d inside {FU_ALU, FU_RED, FU_LOAD};
        xreg_wen <= (fu_d == FU_CFG);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (oi.valid) begin
      fu            <= fu_d;
      aluop         <= aluop_d;
      comp          <= comp_d;
      minmax        <= minmax_d;
      is_signed     <= oi.op inside {OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX, OP_VMSEQ,
                                     OP_VMSNE, OP_VMSLT, OP_VMSLE, OP_VMSGT, OP_VREDSUM,
                                     OP_VREDMIN, OP_VREDMAX};
      // shift amounts and the vsetivli uimm are zero extended
      sign_extend   <= !(oi.op inside {OP_VSLL, OP_VSRL, OP_VSRA, OP_VSETIVLI});
      single_bit_op <= (aluop_d == VALU_COMP);
      rs1_kind      <= oi.rs1_kind;
      rs2_is_x      <= oi.strided;
      mem_width     <= oi.mem_width;
      vs1           <= oi.vs1;
      vs2           <= oi.vs2;
      vd            <= oi.vd;
    end
  end

endmodule

//--- rtl/vector_decoder.sv
// three-stage pipelined RISC-V vector instruction decoder top level
`timescale 1ns/1ps

module vector_decoder import vdec_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        instr_valid,
  input  logic [31:0] instr,
  output logic        ctrl_valid,
  output logic        illegal,
  output fu_t         fu,
  output aluop_t      aluop,
  output comp_t       comp,
  output minmax_t     minmax,
  output logic        is_signed,
  output src_kind_t   rs1_kind,
  output logic        rs2_is_x,
  output logic        sign_extend,
  output logic        single_bit_op,
  output logic        vreg_wen,
  output logic        xreg_wen,
  output logic [2:0]  mem_width,
  output logic [4:0]  vs1,
  output logic [4:0]  vs2,
  output logic [4:0]  vd
);

  vdec_field_if field_bus ();
  vdec_op_if    op_bus ();

  // classify
  vdec_field_stage i_field_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .fo          (field_bus.src)
  );

  // resolve operation
  vdec_op_stage i_op_stage (
    .clk    (clk),
    .arst_n (arst_n),
    .fi     (field_bus.dst),
    .oo     (op_bus.src)
  );

  vdec_ctrl_stage i_ctrl_stage (
    .clk           (clk),
    .arst_n        (arst_n),
    .oi            (op_bus.dst),
    .ctrl_valid    (ctrl_valid),
    .illegal       (illegal),
    .fu            (fu),
    .aluop         (aluop),
    .comp          (comp),
    .minmax        (minmax),
    .is_signed     (is_signed),
    .rs1_kind      (rs1_kind),
    .rs2_is_x      (rs2_is_x),
    .sign_extend   (sign_extend),
    .single_bit_op (single_bit_op),
    .vreg_wen      (vreg_wen),
    .xreg_wen      (xreg_wen),
    .mem_width     (mem_width),
    .vs1           (vs1),
    .vs2           (vs2),
    .vd            (vd)
  );

endmodule

//--- tb/vector_decoder_chk.sv
// protocol and consistency assertions for the vector decoder outputs
`timescale 1ns/1ps

module vector_decoder_chk import vdec_pkg::*; (
  input logic clk,
  input logic arst_n,
  input logic instr_valid,
  input logic ctrl_valid,
  input logic illegal,
  input fu_t  fu,
  input logic vreg_wen,
  input logic xreg_wen
);

  int fail_count = 0;

  // outputs stay quiet while reset is held
  assert property (@(posedge clk) !arst_n |-> !ctrl_valid)
    else begin
      fail_count++;
      $error("ctrl_valid high during reset");
    end

  // fixed latency, one strobe out per strobe in
  assert property (@(posedge clk) disable iff (!arst_n)
    ctrl_valid == $past(instr_valid, PIPE_DEPTH))
    else begin
      fail_count++;
      $error("ctrl_valid does not follow instr_valid by the pipeline depth");
    end

  assert property (@(posedge clk) disable iff (!arst_n)
    illegal |-> (fu == FU_NONE) && !vreg_wen && !xreg_wen)
    else begin
      fail_count++;
      $error("illegal instruction with a unit or a write enable");
    end

  assert property (@(posedge clk) disable iff (!arst_n) !(vreg_wen && xreg_wen))
    else begin
      fail_count++;
      $error("vector and scalar write enables both high");
    end

endmodule

bind vector_decoder vector_decoder_chk i_vector_decoder_chk (.*);

//--- tb/tb_vector_decoder.sv
// testbench for the pipelined vector decoder with reference decode and in-order compare
`timescale 1ns/1ps

module tb_vector_decoder import vdec_pkg::*; ();

  // 512 OP-V sweep, 64 memory, 4 bad opcodes, 400 random, 100 mixed legal
  localparam int N_TOTAL     = 1080;
  localparam int WATCHDOG_NS = N_TOTAL * 4 * 8 + 200;

  typedef struct packed {
    logic       illegal;
    fu_t        fu;
    aluop_t     aluop;
    comp_t      comp;
    minmax_t    minmax;
    logic       is_signed;
    src_kind_t  rs1_kind;
    logic       rs2_is_x;
    logic       sign_extend;
    logic       single_bit_op;
    logic       vreg_wen;
    logic       xreg_wen;
    logic [2:0] mem_width;
    logic [4:0] vs1;
    logic [4:0] vs2;
    logic [4:0] vd;
  } ctrl_t;

  // forms are {vv, vx, vi}, zero when the funct6 is unknown
  typedef struct packed {
    aluop_t     a;
    comp_t      cm;
    minmax_t    mm;
    logic       sg;
    logic [2:0] forms;
  } op_info_t;

  logic clk;
  logic arst_n;
  logic instr_valid;
  logic [31:0] instr;
  logic ctrl_valid;
  logic illegal;
  fu_t fu;
  aluop_t aluop;
  comp_t comp;
  minmax_t minmax;
  logic is_signed;
  src_kind_t rs1_kind;
  logic rs2_is_x;
  logic sign_extend;
  logic single_bit_op;
  logic vreg_wen;
  logic xreg_wen;
  logic [2:0] mem_width;
  logic [4:0] vs1;
  logic [4:0] vs2;
  logic [4:0] vd;

  ctrl_t       exp_q[$];
  string       name_q[$];
  logic [31:0] lfsr_state;
  int          error_count;
  int          sent_count;
  int          checked_count;

  vector_decoder i_vector_decoder (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] r);
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r          = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic op_info_t opi_info(input logic [5:0] f6);
    case (f6)
      F6_VADD:   return '{VALU_ADD, VSEQ, MIN, 1'b1, 3'b111};
      F6_VSUB:   return '{VALU_SUB, VSEQ, MIN, 1'b1, 3'b110};
      F6_VRSUB:  return '{VALU_SUB, VSEQ, MIN, 1'b1, 3'b011};
      F6_VMINU:  return '{VALU_MM, VSEQ, MINU, 1'b0, 3'b110};
      F6_VMIN:   return '{VALU_MM, VSEQ, MIN, 1'b1, 3'b110};
      F6_VMAXU:  return '{VALU_MM, VSEQ, MAXU, 1'b0, 3'b110};
      F6_VMAX:   return '{VALU_MM, VSEQ, MAX, 1'b1, 3'b110};
      F6_VAND:   return '{VALU_AND, VSEQ, MIN, 1'b0, 3'b111};
      F6_VOR:    return '{VALU_OR, VSEQ, MIN, 1'b0, 3'b111};
      F6_VXOR:   return '{VALU_XOR, VSEQ, MIN, 1'b0, 3'b111};
      F6_VMSEQ:  return '{VALU_COMP, VSEQ, MIN, 1'b1, 3'b111};
      F6_VMSNE:  return '{VALU_COMP, VSNE, MIN, 1'b1, 3'b111};
      F6_VMSLTU: return '{VALU_COMP, VSLTU, MIN, 1'b0, 3'b110};
      F6_VMSLT:  return '{VALU_COMP, VSLT, MIN, 1'b1, 3'b110};
      F6_VMSLEU: return '{VALU_COMP, VSLEU, MIN, 1'b0, 3'b111};
      F6_VMSLE:  return '{VALU_COMP, VSLE, MIN, 1'b1, 3'b111};
      F6_VMSGTU: return '{VALU_COMP, VSGTU, MIN, 1'b0, 3'b011};
      F6_VMSGT:  return '{VALU_COMP, VSGT, MIN, 1'b1, 3'b011};
      F6_VSLL:   return '{VALU_SLL, VSEQ, MIN, 1'b0, 3'b111};
      F6_VSRL:   return '{VALU_SRL, VSEQ, MIN, 1'b0, 3'b111};
      F6_VSRA:   return '{VALU_SRA, VSEQ, MIN, 1'b0, 3'b111};
      default:   return '{VALU_NONE, VSEQ, MIN, 1'b0, 3'b000};
    endcase
  endfunction

  // reductions only exist in the vv form
  function automatic op_info_t red_info(input logic [5:0] f6);
    case (f6)
      F6_VREDSUM:  return '{VALU_ADD, VSEQ, MIN, 1'b1, 3'b100};
      F6_VREDAND:  return '{VALU_AND, VSEQ, MIN, 1'b0, 3'b100};
      F6_VREDOR:   return '{VALU_OR, VSEQ, MIN, 1'b0, 3'b100};
      F6_VREDXOR:  return '{VALU_XOR, VSEQ, MIN, 1'b0, 3'b100};
      F6_VREDMINU: return '{VALU_MM, VSEQ, MINU, 1'b0, 3'b100};
      F6_VREDMIN:  return '{VALU_MM, VSEQ, MIN, 1'b1, 3'b100};
      F6_VREDMAXU: return '{VALU_MM, VSEQ, MAXU, 1'b0, 3'b100};
      F6_VREDMAX:  return '{VALU_MM, VSEQ, MAX, 1'b1, 3'b100};
      default:     return '{VALU_NONE, VSEQ, MIN, 1'b0, 3'b000};
    endcase
  endfunction

  function automatic ctrl_t decode_ref(input logic [31:0] w);
    ctrl_t      c;
    op_info_t   info;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [2:0] form;
    logic       use_info;
    opc           = w[6:0];
    f3            = w[14:12];
    use_info      = 1'b0;
    c             = '0;
    c.illegal     = 1'b1;
    c.sign_extend = 1'b1;
    c.vs1         = w[19:15];
    c.vs2         = w[24:20];
    c.vd          = w[11:7];
    if (opc == OPC_VECTOR && f3 inside {F3_OPIVV, F3_OPIVX, F3_OPIVI}) begin
      info = opi_info(w[31:26]);
      form = (f3 == F3_OPIVV) ? 3'b100 : ((f3 == F3_OPIVX) ? 3'b010 : 3'b001);
      if (f3 == F3_OPIVX) c.rs1_kind = SRC_X;
      if (f3 == F3_OPIVI) c.rs1_kind = SRC_I;
      if ((info.forms & form) != 3'b000) begin
        use_info      = 1'b1;
        c.fu          = FU_ALU;
        c.sign_extend = !(info.a inside {VALU_SLL, VALU_SRL, VALU_SRA});
      end
    end else if (opc == OPC_VECTOR && f3 == F3_OPMVV) begin
      info = red_info(w[31:26]);
      if (info.forms != 3'b000) begin
        use_info = 1'b1;
        c.fu     = FU_RED;
      end
    end else if (opc == OPC_VECTOR && f3 == F3_OPCFG) begin
      c.illegal  = 1'b0;
      c.fu       = FU_CFG;
      c.xreg_wen = 1'b1;
      c.rs1_kind = SRC_X;
      // vsetivli carries a zero-extended uimm
      if (w[31:30] == 2'b11) begin
        c.rs1_kind    = SRC_I;
        c.sign_extend = 1'b0;
      end
    end else if ((opc == OPC_LOAD_FP || opc == OPC_STORE_FP) &&
                 (f3 inside {W_8, W_16, W_32})) begin
      c.illegal   = 1'b0;
      c.rs1_kind  = SRC_X;
      c.mem_width = f3;
      c.rs2_is_x  = (w[27:26] == MOP_STRIDED);
      if (opc == OPC_LOAD_FP) begin
        c.fu       = FU_LOAD;
        c.vreg_wen = 1'b1;
      end else begin
        c.fu = FU_STORE;
      end
    end
    if (use_info) begin
      c.illegal       = 1'b0;
      c.vreg_wen      = 1'b1;
      c.aluop         = info.a;
      c.comp          = info.cm;
      c.minmax        = info.mm;
      c.is_signed     = info.sg;
      c.single_bit_op = (info.a == VALU_COMP);
    end
    return c;
  endfunction

  function automatic logic [31:0] legal_word(input logic [1:0] k, input logic [31:0] r);
    case (k)
      2'd0:    return {F6_VADD, 1'b1, r[24:20], r[19:15], F3_OPIVX, r[11:7], OPC_VECTOR};
      2'd1:    return {F6_VREDMAX, 1'b1, r[24:20], r[19:15], F3_OPMVV, r[11:7], OPC_VECTOR};
      2'd2:    return {2'b11, r[29:15], F3_OPCFG, r[11:7], OPC_VECTOR};
      default: return {3'b000, 1'b0, MOP_STRIDED, 1'b1, r[24:20], r[19:15], W_16, r[11:7],
                       OPC_LOAD_FP};
    endcase
  endfunction

  task automatic send(input logic [31:0] w, input string name);
    @(negedge clk);
    instr       = w;
    instr_valid = 1'b1;
    exp_q.push_back(decode_ref(w));
    name_q.push_back(name);
    sent_count++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      instr_valid = 1'b0;
    end
  endtask

  task automatic check_val(input string test, input string field,
                           input logic [31:0] exp_v, input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      error_count++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", test, field, exp_v, act_v);
    end
  endtask

  // outputs settle after the rising edge, so compare on the falling one
  always @(negedge clk) begin : compare_proc
    ctrl_t e;
    string n;
    if (arst_n && ctrl_valid) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("ctrl_valid seen with no instruction outstanding at %0t", $time);
      end else begin
        e = exp_q.pop_front();
        n = name_q.pop_front();
        checked_count++;
        check_val(n, "illegal", e.illegal, illegal);
        check_val(n, "fu", e.fu, fu);
        check_val(n, "aluop", e.aluop, aluop);
        check_val(n, "comp", e.comp, comp);
        check_val(n, "minmax", e.minmax, minmax);
        check_val(n, "is_signed", e.is_signed, is_signed);
        check_val(n, "rs1_kind", e.rs1_kind, rs1_kind);
        check_val(n, "rs2_is_x", e.rs2_is_x, rs2_is_x);
        check_val(n, "sign_extend", e.sign_extend, sign_extend);
        check_val(n, "single_bit_op", e.single_bit_op, single_bit_op);
        check_val(n, "vreg_wen", e.vreg_wen, vreg_wen);
        check_val(n, "xreg_wen", e.xreg_wen, xreg_wen);
        check_val(n, "mem_width", e.mem_width, mem_width);
        check_val(n, "vs1", e.vs1, vs1);
        check_val(n, "vs2", e.vs2, vs2);
        check_val(n, "vd", e.vd, vd);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all instructions were checked");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] w;
    int          f3;
    int          f6;
    int          wd;
    int          mop;
    int          i;
    error_count   = 0;
    sent_count    = 0;
    checked_count = 0;
    lfsr_state    = 32'd98070;
    instr_valid   = 1'b0;
    instr         = '0;
    arst_n        = 1'b1;
    #1 arst_n     = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // every funct3 and funct6 of OP-V, back to back
    for (f3 = 0; f3 < 8; f3++) begin
      for (f6 = 0; f6 < 64; f6++) begin
        rand_bits(32, r);
        w = {f6[5:0], r[25:15], f3[2:0], r[11:7], OPC_VECTOR};
        send(w, $sformatf("opv_f3_%0d_f6_%02h", f3, f6));
      end
    end
    idle(2);

    // loads and stores, all widths including the unsupported ones
    for (wd = 0; wd < 8; wd++) begin
      for (mop = 0; mop < 4; mop++) begin
        rand_bits(32, r);
        send({4'b0000, mop[1:0], r[25:15], wd[2:0], r[11:7], OPC_LOAD_FP},
             $sformatf("load_w%0d_mop%0d", wd, mop));
        send({4'b0000, mop[1:0], r[25:15], wd[2:0], r[11:7], OPC_STORE_FP},
             $sformatf("store_w%0d_mop%0d", wd, mop));
      end
    end
    idle(1);

    rand_bits(32, r);
    send({r[31:7], 7'b0110011}, "bad_opcode_op");
    send({r[31:7], 7'b0000011}, "bad_opcode_load");
    send({r[31:7], 7'b1010011}, "bad_opcode_opfp");
    send({r[31:7], 7'b1111111}, "bad_opcode_ones");

    // random words, biased toward the decoded opcodes, with random gaps
    for (i = 0; i < 400; i++) begin
      rand_bits(32, r);
      rand_bits(2, s);
      case (s[1:0])
        2'd0:    w = {r[31:7], OPC_VECTOR};
        2'd1:    w = {r[31:7], OPC_LOAD_FP};
        2'd2:    w = {r[31:7], OPC_STORE_FP};
        default: w = r;
      endcase
      send(w, $sformatf("random_%0d", i));
      if (i % 4 == 3) begin
        rand_bits(2, s);
        rand_bits(32, r);
        send(legal_word(s[1:0], r), $sformatf("mixed_legal_%0d", i));
      end
      rand_bits(2, s);
      idle(s[1:0]);
    end

    idle(PIPE_DEPTH + 2);
    if (exp_q.size() != 0) begin
      error_count++;
      $display("%0d instructions never produced ctrl_valid", exp_q.size());
    end
    if (i_vector_decoder.i_vector_decoder_chk.fail_count != 0) begin
      error_count += i_vector_decoder.i_vector_decoder_chk.fail_count;
      $display("%0d assertion failures in the output checker",
               i_vector_decoder.i_vector_decoder_chk.fail_count);
    end
    $display("sent %0d, checked %0d, errors %0d", sent_count, checked_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
rtl/vdec_pkg.sv
rtl/vdec_field_if.sv
rtl/vdec_op_if.sv
rtl/vdec_field_stage.sv
rtl/vdec_op_stage.sv
rtl/vdec_ctrl_stage.sv
rtl/vector_decoder.sv
tb/vector_decoder_chk.sv
tb/tb_vector_decoder.sv
